//--- Bender.yml
package:
  name: eth_switch

sources:
  - include_dirs:
      - hw
    files:
      - hw/sw_pkg.sv
      - hw/ingress_buffer.sv
      - hw/mac_table.sv
      - hw/fwd_decide.sv
      - hw/frame_scheduler.sv
      - hw/sw_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/tb_sw_top.sv

//--- all.f
+incdir+hw
hw/sw_pkg.sv
hw/ingress_buffer.sv
hw/mac_table.sv
hw/fwd_decide.sv
hw/frame_scheduler.sv
hw/sw_top.sv
bench/tb_sw_top.sv

//--- bench/sw_stimulus.txt
# port dst_mac src_mac beats seed port_enable expected_mask expected_learned
# Beat k carries seed+k; port_enable and masks are hex with bit n for port n
0 020000000099 020000000010 4 10000000 f e 1
1 020000000099 020000000011 5 20000010 f d 2
2 ffffffffffff 020000000012 3 30000020 f b 3
0 020000000012 020000000010 6 40000030 f 4 3
3 020000000010 020000000013 2 50000040 f 1 4
1 01005e000001 020000000011 7 60000050 f d 4
3 01005e0000fb 020000000013 4 70000060 7 7 4
0 020000000012 020000000010 3 80000070 b 0 4
2 020000000012 020000000012 2 90000080 f 0 4
1 ffffffffffff 020000000011 5 a0000090 2 0 4
3 020000000077 020000000014 6 b00000a0 c 4 5
2 020000000014 020000000012 8 c00000b0 f 8 5
0 020000000011 020000000010 16 fffffff8 f 2 5
1 ffffffffffff 020000000015 12 d00000c0 f d 6
3 020000000012 020000000010 3 e00000d0 f 4 6
2 020000000010 020000000012 4 f00000e0 f 8 6
0 020000000099 020000000010 1 123400f0 f e 6
3 020000000010 020000000013 2 23450100 f 1 6
0 020000000010 020000000010 3 34560110 f 0 6
2 333300000001 020000000012 10 45670120 f b 6
1 020000000013 020000000011 9 56780130 7 0 6
3 020000000011 020000000016 5 67890140 f 2 7
2 0200000000aa 020000000017 4 789a0150 9 9 8
0 ffffffffffff 020000000018 6 89ab0160 f e 9

//--- bench/tb_sw_top.sv
//**************************************************************************
// Testbench for the four-port switch: file-driven frames, random egress
// back-pressure, per-port egress monitors, counter checks and watchdog
//**************************************************************************

`timescale 1ns/1ps
`include "sw_macros.svh"

module tb_sw_top;

    localparam int NP        = `SW_NUM_PORTS;
    localparam int MAX_FRAME = 64;
    localparam int MAX_BEATS = 64;

    logic                            clk;
    logic                            rst_n;
    sw_pkg::port_mask_t              rx_valid_i;
    sw_pkg::port_mask_t              rx_sof_i;
    sw_pkg::port_mask_t              rx_eof_i;
    sw_pkg::data_t [NP-1:0]          rx_data_i;
    sw_pkg::mac_addr_t [NP-1:0]      rx_dst_i;
    sw_pkg::mac_addr_t [NP-1:0]      rx_src_i;
    sw_pkg::port_mask_t              rx_ready_o;
    sw_pkg::port_mask_t              tx_valid_o;
    sw_pkg::port_mask_t              tx_sof_o;
    sw_pkg::port_mask_t              tx_eof_o;
    sw_pkg::data_t [NP-1:0]          tx_data_o;
    sw_pkg::port_mask_t              tx_ready_i;
    logic                            learning_enable_i;
    sw_pkg::port_mask_t              port_enable_i;
    sw_pkg::count_t [NP-1:0]         forwarded_o;
    sw_pkg::count_t [NP-1:0]         dropped_o;
    sw_pkg::count_t                  learned_o;

    // One entry per line of the stimulus file
    int                 f_port    [MAX_FRAME];
    sw_pkg::mac_addr_t  f_dst     [MAX_FRAME];
    sw_pkg::mac_addr_t  f_src     [MAX_FRAME];
    int                 f_beats   [MAX_FRAME];
    sw_pkg::data_t      f_seed    [MAX_FRAME];
    sw_pkg::port_mask_t f_enable  [MAX_FRAME];
    sw_pkg::port_mask_t f_mask    [MAX_FRAME];
    int                 f_learned [MAX_FRAME];
    int                 frame_total;

    sw_pkg::port_mask_t cur_mask;       // Expected egress ports of the running frame
    int                 cur_beats;
    sw_pkg::port_mask_t eof_seen;
    int                 got_cnt  [NP];
    sw_pkg::data_t      got_data [NP][MAX_BEATS];
    int                 error_count;
    int                 watchdog_cycles;

    sw_top u_sw_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .rx_valid_i        (rx_valid_i),
        .rx_sof_i          (rx_sof_i),
        .rx_eof_i          (rx_eof_i),
        .rx_data_i         (rx_data_i),
        .rx_dst_i          (rx_dst_i),
        .rx_src_i          (rx_src_i),
        .rx_ready_o        (rx_ready_o),
        .tx_valid_o        (tx_valid_o),
        .tx_sof_o          (tx_sof_o),
        .tx_eof_o          (tx_eof_o),
        .tx_data_o         (tx_data_o),
        .tx_ready_i        (tx_ready_i),
        .learning_enable_i (learning_enable_i),
        .port_enable_i     (port_enable_i),
        .forwarded_o       (forwarded_o),
        .dropped_o         (dropped_o),
        .learned_o         (learned_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Each port ready about three cycles in four
    initial begin : back_pressure
        void'($urandom(32'hb3eb829d));
        forever begin
            @(posedge clk);
            #2;
            tx_ready_i = sw_pkg::port_mask_t'($urandom | $urandom);
        end
    end

    // Beats are sampled mid-cycle and transfer at the following edge
    always @(negedge clk) begin : egress_monitor
        logic first_exp;
        logic last_exp;
        for (int p = 0; p < NP; p++) begin
            if (rst_n && tx_valid_o[p] && !cur_mask[p]) begin
                $display("FAILED t=%0t tx_valid_o[%0d]: got 1 expected 0, port outside mask %b",
                         $time, p, cur_mask);
                error_count++;
            end else if (rst_n && tx_valid_o[p] && tx_ready_i[p]) begin
                first_exp = (got_cnt[p] == 0);
                last_exp  = (got_cnt[p] == cur_beats - 1);
                if (tx_sof_o[p] != first_exp) begin
                    $display("FAILED t=%0t tx_sof_o[%0d]: got %b expected %b",
                             $time, p, tx_sof_o[p], first_exp);
                    error_count++;
                end
                if (tx_eof_o[p] != last_exp) begin
                    $display("FAILED t=%0t tx_eof_o[%0d]: got %b expected %b",
                             $time, p, tx_eof_o[p], last_exp);
                    error_count++;
                end
                if (got_cnt[p] < MAX_BEATS) got_data[p][got_cnt[p]] = tx_data_o[p];
                got_cnt[p]++;
                if (tx_eof_o[p]) eof_seen[p] = 1'b1;
            end
        end
    end

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        frame_total = 0;
        fd = $fopen("bench/sw_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file bench/sw_stimulus.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && frame_total < MAX_FRAME) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %d %h %h %h %d", f_port[frame_total],
                                f_dst[frame_total], f_src[frame_total], f_beats[frame_total],
                                f_seed[frame_total], f_enable[frame_total],
                                f_mask[frame_total], f_learned[frame_total]);
                    if (n == 8) frame_total++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Called 2 ns after a rising edge, returns at the same phase
    task automatic send_frame(input int f);
        int p;
        int k;
        bit accepted;
        p = f_port[f];
        for (k = 0; k < f_beats[f]; k++) begin
            rx_valid_i[p] = 1'b1;
            rx_sof_i[p]   = (k == 0);
            rx_eof_i[p]   = (k == f_beats[f] - 1);
            rx_data_i[p]  = f_seed[f] + sw_pkg::data_t'(k);
            rx_dst_i[p]   = f_dst[f];
            rx_src_i[p]   = f_src[f];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = rx_ready_o[p];
                @(posedge clk);
                #2;
            end
        end
        rx_valid_i[p] = 1'b0;
        rx_sof_i[p]   = 1'b0;
        rx_eof_i[p]   = 1'b0;
    endtask

    task automatic run_frame(input int f);
        int             p;
        int             k;
        int             errs_before;
        sw_pkg::count_t drop_before;
        sw_pkg::data_t  exp_data;
        p           = f_port[f];
        errs_before = error_count;
        cur_mask    = f_mask[f];
        cur_beats   = f_beats[f];
        eof_seen    = '0;
        for (int q = 0; q < NP; q++) got_cnt[q] = 0;
        port_enable_i = f_enable[f];
        drop_before   = dropped_o[p];
        send_frame(f);
        if (f_mask[f] != '0) wait ((eof_seen & f_mask[f]) == f_mask[f]);
        else wait (dropped_o[p] != drop_before);
        @(negedge clk);     // Last beat taken, counters settled
        for (int q = 0; q < NP; q++) begin
            if (cur_mask[q] && got_cnt[q] != cur_beats) begin
                $display("FAILED t=%0t beat count on tx port %0d: got %0d expected %0d",
                         $time, q, got_cnt[q], cur_beats);
                error_count++;
            end
            for (k = 0; k < got_cnt[q] && k < cur_beats && k < MAX_BEATS; k++) begin
                exp_data = f_seed[f] + sw_pkg::data_t'(k);
                if (got_data[q][k] != exp_data) begin
                    $display("FAILED t=%0t tx_data_o[%0d] beat %0d: got %h expected %h",
                             $time, q, k, got_data[q][k], exp_data);
                    error_count++;
                end
            end
        end
        if (learned_o != sw_pkg::count_t'(f_learned[f])) begin
            $display("FAILED t=%0t learned_o: got %0d expected %0d", $time, learned_o,
                     f_learned[f]);
            error_count++;
        end
        $display("Frame %0d from port %0d, mask %b: %s", f, p, f_mask[f],
                 (error_count == errs_before) ? "ok" : "errors");
        @(posedge clk);
        #2;
    endtask

    task automatic check_counters();
        int exp_fwd  [NP];
        int exp_drop [NP];
        for (int p = 0; p < NP; p++) begin
            exp_fwd[p]  = 0;
            exp_drop[p] = 0;
        end
        for (int f = 0; f < frame_total; f++) begin
            if (f_mask[f] != '0) exp_fwd[f_port[f]]++;
            else exp_drop[f_port[f]]++;
        end
        for (int p = 0; p < NP; p++) begin
            if (forwarded_o[p] != sw_pkg::count_t'(exp_fwd[p])) begin
                $display("FAILED t=%0t forwarded_o[%0d]: got %0d expected %0d",
                         $time, p, forwarded_o[p], exp_fwd[p]);
                error_count++;
            end
            if (dropped_o[p] != sw_pkg::count_t'(exp_drop[p])) begin
                $display("FAILED t=%0t dropped_o[%0d]: got %0d expected %0d",
                         $time, p, dropped_o[p], exp_drop[p]);
                error_count++;
            end
        end
        $display("Per-port counters checked");
    endtask

    initial begin : main_flow
        int total_beats;
        rst_n             = 1'b0;
        rx_valid_i        = '0;
        rx_sof_i          = '0;
        rx_eof_i          = '0;
        rx_data_i         = '0;
        rx_dst_i          = '0;
        rx_src_i          = '0;
        tx_ready_i        = '0;
        learning_enable_i = 1'b0;
        port_enable_i     = '1;
        cur_mask          = '0;
        cur_beats         = 0;
        eof_seen          = '0;
        error_count       = 0;
        watchdog_cycles   = 0;
        load_stimulus();
        if (frame_total == 0) begin
            $display("The stimulus file holds no frames");
            error_count++;
        end
        total_beats = 0;
        for (int f = 0; f < frame_total; f++) total_beats += f_beats[f];
        watchdog_cycles = total_beats * 40 + 2000;
        repeat (10) @(posedge clk);
        #2;
        rst_n             = 1'b1;
        learning_enable_i = 1'b1;
        @(negedge clk);
        // Idle switch accepts on every port and sends nothing
        if (rx_ready_o != {NP{1'b1}}) begin
            $display("FAILED t=%0t rx_ready_o: got %b expected %b", $time, rx_ready_o,
                     {NP{1'b1}});
            error_count++;
        end
        if (tx_valid_o != '0) begin
            $display("FAILED t=%0t tx_valid_o: got %b expected %b", $time, tx_valid_o,
                     {NP{1'b0}});
            error_count++;
        end
        @(posedge clk);
        #2;
        for (int f = 0; f < frame_total; f++) run_frame(f);
        check_counters();
        $display("Frames run: %0d, errors: %0d", frame_total, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, a frame never completed", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- hw/frame_scheduler.sv
//**************************************************************************
// Frame scheduler: round-robin pick of a waiting frame, learn and decide
// step, multicast streaming under back-pressure, per-port counters
//**************************************************************************

`timescale 1ns/1ps
`include "sw_macros.svh"

module frame_scheduler (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  sw_pkg::port_mask_t                    hdr_valid_i,
    input  sw_pkg::mac_addr_t [`SW_NUM_PORTS-1:0] hdr_dst_i,
    input  sw_pkg::mac_addr_t [`SW_NUM_PORTS-1:0] hdr_src_i,
    output sw_pkg::port_mask_t                    hdr_pop_o,
    input  sw_pkg::port_mask_t                    beat_valid_i,
    input  sw_pkg::data_t [`SW_NUM_PORTS-1:0]     beat_data_i,
    input  sw_pkg::port_mask_t                    beat_eof_i,
    output sw_pkg::port_mask_t                    beat_pop_o,
    output sw_pkg::mac_addr_t                     lookup_mac_o,
    input  logic                                  hit_i,
    input  sw_pkg::port_idx_t                     hit_port_i,
    output logic                                  learn_o,
    output sw_pkg::mac_addr_t                     learn_mac_o,
    output sw_pkg::port_idx_t                     learn_port_o,
    output sw_pkg::port_idx_t                     ingress_o,
    input  sw_pkg::port_mask_t                    egress_mask_i,
    input  logic                                  learning_enable_i,
    output sw_pkg::port_mask_t                    tx_valid_o,
    output sw_pkg::port_mask_t                    tx_sof_o,
    output sw_pkg::port_mask_t                    tx_eof_o,
    output sw_pkg::data_t [`SW_NUM_PORTS-1:0]     tx_data_o,
    input  sw_pkg::port_mask_t                    tx_ready_i,
    output sw_pkg::count_t [`SW_NUM_PORTS-1:0]    forwarded_o,
    output sw_pkg::count_t [`SW_NUM_PORTS-1:0]    dropped_o
);

    sw_pkg::sched_state_t state;
    sw_pkg::port_idx_t    rr_ptr;
    sw_pkg::port_idx_t    cur_port;
    sw_pkg::port_idx_t    grant;
    sw_pkg::port_mask_t   cur_mask;
    sw_pkg::port_mask_t   cur_bit;
    sw_pkg::mac_addr_t    cur_dst;
    sw_pkg::mac_addr_t    cur_src;
    logic                 grant_found;
    logic                 tx_busy;
    logic                 first_beat;
    logic                 load;
    logic                 drain_pop;
    logic                 eof_taken;

    // First waiting port at or after the pointer
    always_comb begin
        grant       = rr_ptr;
        grant_found = 1'b0;
        for (int i = 0; i < `SW_NUM_PORTS; i++) begin
            if (!grant_found && hdr_valid_i[sw_pkg::port_idx_t'(rr_ptr + i)]) begin
                grant       = sw_pkg::port_idx_t'(rr_ptr + i);
                grant_found = 1'b1;
            end
        end
    end

    assign cur_bit = sw_pkg::port_mask_t'(1) << cur_port;
    assign tx_busy = |(tx_valid_o & ~tx_ready_i);   // Some port keeps its beat

    // Old beats must drain before a new frame is picked
    assign hdr_pop_o = (state == sw_pkg::SCHED_IDLE && grant_found && !tx_busy) ?
                       (sw_pkg::port_mask_t'(1) << grant) : '0;

    assign load       = (state == sw_pkg::SCHED_STREAM) && !tx_busy && beat_valid_i[cur_port];
    assign drain_pop  = (state == sw_pkg::SCHED_DRAIN) && beat_valid_i[cur_port];
    assign eof_taken  = (load || drain_pop) && beat_eof_i[cur_port];
    assign beat_pop_o = (load || drain_pop) ? cur_bit : '0;

    assign lookup_mac_o = cur_dst;
    assign learn_mac_o  = cur_src;
    assign learn_port_o = cur_port;
    assign ingress_o    = cur_port;
    assign learn_o      = (state == sw_pkg::SCHED_DECIDE) && learning_enable_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= sw_pkg::SCHED_IDLE;
            rr_ptr      <= '0;
            cur_port    <= '0;
            cur_mask    <= '0;
            first_beat  <= 1'b0;
            forwarded_o <= '0;
            dropped_o   <= '0;
        end else begin
            case (state)
                sw_pkg::SCHED_IDLE: begin
                    if (|hdr_pop_o) begin
                        cur_port <= grant;
                        state    <= sw_pkg::SCHED_DECIDE;
                    end
                end
                sw_pkg::SCHED_DECIDE: begin
                    cur_mask   <= egress_mask_i;
                    rr_ptr     <= cur_port + 1'b1;
                    first_beat <= 1'b1;
                    if (|egress_mask_i) begin
                        forwarded_o[cur_port] <= forwarded_o[cur_port] + 1'b1;
                        state                 <= sw_pkg::SCHED_STREAM;
                    end else begin
                        dropped_o[cur_port] <= dropped_o[cur_port] + 1'b1;
                        state               <= sw_pkg::SCHED_DRAIN;
                    end
                end
                default: begin                  // STREAM or DRAIN
                    if (load) first_beat <= 1'b0;
                    if (eof_taken) state <= sw_pkg::SCHED_IDLE;
                end
            endcase
        end
    end

    // Header is captured as it leaves the buffer
    always_ff @(posedge clk) begin
        if (|hdr_pop_o) begin
            cur_dst <= hdr_dst_i[grant];
            cur_src <= hdr_src_i[grant];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid_o <= '0;
            tx_sof_o   <= '0;
            tx_eof_o   <= '0;
        end else if (load) begin
            tx_valid_o <= cur_mask;             // All masked ports together
            tx_sof_o   <= first_beat ? cur_mask : '0;
            tx_eof_o   <= beat_eof_i[cur_port] ? cur_mask : '0;
        end else begin
            tx_valid_o <= tx_valid_o & ~tx_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            if (load && cur_mask[p]) tx_data_o[p] <= beat_data_i[cur_port];
        end
    end

    // Stream never leaks onto a port outside the latched decision
    a_tx_in_mask: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid_o & ~cur_mask) == '0);

endmodule

//--- hw/fwd_decide.sv
//**************************************************************************
// Forwarding decision: egress mask for group, known and unknown unicast
//**************************************************************************

`timescale 1ns/1ps

module fwd_decide (
    input  sw_pkg::mac_addr_t  dst_mac_i,
    input  sw_pkg::port_idx_t  ingress_i,
    input  logic               hit_i,
    input  sw_pkg::port_idx_t  hit_port_i,
    input  sw_pkg::port_mask_t port_enable_i,
    output sw_pkg::port_mask_t egress_mask_o
);

    sw_pkg::port_mask_t ingress_bit;
    sw_pkg::port_mask_t learned_bit;
    sw_pkg::port_mask_t rule_mask;

    assign ingress_bit = sw_pkg::port_mask_t'(1) << ingress_i;
    assign learned_bit = sw_pkg::port_mask_t'(1) << hit_port_i;

    always_comb begin
        if (dst_mac_i[40]) begin
            rule_mask = '1;                 // Group address, broadcast too
        end else if (hit_i) begin
            rule_mask = learned_bit;
        end else begin
            rule_mask = '1;                 // Unknown unicast floods
        end
    end

    // Removing the ingress port also filters a frame learned on its own port
    assign egress_mask_o = rule_mask & ~ingress_bit & port_enable_i;

endmodule

//--- hw/ingress_buffer.sv
//**************************************************************************
// Ingress buffer for one port: beat FIFO with eof flags, header queue
// written on sof beats, and the rx valid/ready handshake
//**************************************************************************

`timescale 1ns/1ps
`include "sw_macros.svh"

module ingress_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx_valid_i,
    output logic              rx_ready_o,
    input  logic              rx_sof_i,
    input  logic              rx_eof_i,
    input  sw_pkg::data_t     rx_data_i,
    input  sw_pkg::mac_addr_t rx_dst_i,
    input  sw_pkg::mac_addr_t rx_src_i,
    output logic              hdr_valid_o,
    output sw_pkg::mac_addr_t hdr_dst_o,
    output sw_pkg::mac_addr_t hdr_src_o,
    input  logic              hdr_pop_i,
    output logic              beat_valid_o,
    output sw_pkg::data_t     beat_data_o,
    output logic              beat_eof_o,
    input  logic              beat_pop_i
);

    localparam int BEAT_AW = $clog2(`SW_FIFO_DEPTH);
    localparam int HDR_AW  = $clog2(`SW_HDR_DEPTH);

    sw_pkg::data_t     beat_mem [`SW_FIFO_DEPTH];
    logic              eof_mem  [`SW_FIFO_DEPTH];
    sw_pkg::mac_addr_t dst_mem  [`SW_HDR_DEPTH];
    sw_pkg::mac_addr_t src_mem  [`SW_HDR_DEPTH];

    logic [BEAT_AW:0] beat_wr_ptr;  // MSB separates full from empty
    logic [BEAT_AW:0] beat_rd_ptr;
    logic [HDR_AW:0]  hdr_wr_ptr;
    logic [HDR_AW:0]  hdr_rd_ptr;
    logic             beat_full;
    logic             hdr_full;
    logic             beat_push;
    logic             hdr_push;

    assign beat_full = (beat_wr_ptr - beat_rd_ptr) == (BEAT_AW + 1)'(`SW_FIFO_DEPTH);
    assign hdr_full  = (hdr_wr_ptr - hdr_rd_ptr) == (HDR_AW + 1)'(`SW_HDR_DEPTH);

    // A sof beat also needs room in the header queue
    assign rx_ready_o = !beat_full && !(rx_sof_i && hdr_full);
    assign beat_push  = rx_valid_i && rx_ready_o;
    assign hdr_push   = beat_push && rx_sof_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_wr_ptr <= '0;
            beat_rd_ptr <= '0;
            hdr_wr_ptr  <= '0;
            hdr_rd_ptr  <= '0;
        end else begin
            if (beat_push) beat_wr_ptr <= beat_wr_ptr + 1'b1;
            if (beat_pop_i) beat_rd_ptr <= beat_rd_ptr + 1'b1;
            if (hdr_push) hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
            if (hdr_pop_i) hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_push) begin
            beat_mem[beat_wr_ptr[BEAT_AW-1:0]] <= rx_data_i;
            eof_mem[beat_wr_ptr[BEAT_AW-1:0]]  <= rx_eof_i;
        end
        if (hdr_push) begin
            dst_mem[hdr_wr_ptr[HDR_AW-1:0]] <= rx_dst_i;
            src_mem[hdr_wr_ptr[HDR_AW-1:0]] <= rx_src_i;
        end
    end

    assign beat_valid_o = beat_wr_ptr != beat_rd_ptr;
    assign beat_data_o  = beat_mem[beat_rd_ptr[BEAT_AW-1:0]];
    assign beat_eof_o   = eof_mem[beat_rd_ptr[BEAT_AW-1:0]];
    assign hdr_valid_o  = hdr_wr_ptr != hdr_rd_ptr;  // Same cycle as its sof beat
    assign hdr_dst_o    = dst_mem[hdr_rd_ptr[HDR_AW-1:0]];
    assign hdr_src_o    = src_mem[hdr_rd_ptr[HDR_AW-1:0]];

    // Scheduler only takes what the buffer presents
    a_beat_pop: assert property (@(posedge clk) disable iff (!rst_n)
        beat_pop_i |-> beat_valid_o);
    a_hdr_pop: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_pop_i |-> hdr_valid_o);
    // Occupancy stays within the storage
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        ((beat_wr_ptr - beat_rd_ptr) <= (BEAT_AW + 1)'(`SW_FIFO_DEPTH)) &&
        ((hdr_wr_ptr - hdr_rd_ptr) <= (HDR_AW + 1)'(`SW_HDR_DEPTH)));

endmodule

//--- hw/mac_table.sv
//**************************************************************************
// MAC address table: parallel lookup, learning with update or append,
// and the count of learned addresses
//**************************************************************************

`timescale 1ns/1ps
`include "sw_macros.svh"

module mac_table (
    input  logic              clk,
    input  logic              rst_n,
    input  sw_pkg::mac_addr_t lookup_mac_i,
    output logic              hit_o,
    output sw_pkg::port_idx_t hit_port_o,
    input  logic              learn_i,
    input  sw_pkg::mac_addr_t learn_mac_i,
    input  sw_pkg::port_idx_t learn_port_i,
    output sw_pkg::count_t    learned_o
);

    localparam int IDX_W = $clog2(`SW_MAC_ENTRIES);

    sw_pkg::mac_addr_t          entry_mac  [`SW_MAC_ENTRIES];
    sw_pkg::port_idx_t          entry_port [`SW_MAC_ENTRIES];
    logic [`SW_MAC_ENTRIES-1:0] entry_valid;
    logic [`SW_MAC_ENTRIES-1:0] lookup_hit;
    logic [`SW_MAC_ENTRIES-1:0] learn_hit;
    logic [IDX_W-1:0]           free_idx;
    logic                       table_full;
    logic                       append;

    always_comb begin
        hit_port_o = '0;
        for (int i = 0; i < `SW_MAC_ENTRIES; i++) begin
            lookup_hit[i] = entry_valid[i] && (entry_mac[i] == lookup_mac_i);
            learn_hit[i]  = entry_valid[i] && (entry_mac[i] == learn_mac_i);
            if (lookup_hit[i]) hit_port_o = entry_port[i];
        end
    end

    assign hit_o = |lookup_hit;

    // Entries fill in order, so the count points at the next free slot
    assign table_full = learned_o == sw_pkg::count_t'(`SW_MAC_ENTRIES);
    assign free_idx   = learned_o[IDX_W-1:0];
    assign append     = learn_i && !(|learn_hit) && !table_full;  // Full table stops learning

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            learned_o   <= '0;
        end else if (append) begin
            entry_valid[free_idx] <= 1'b1;
            learned_o             <= learned_o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `SW_MAC_ENTRIES; i++) begin
            if (learn_i && learn_hit[i]) entry_port[i] <= learn_port_i;  // Station moved
        end
        if (append) begin
            entry_mac[free_idx]  <= learn_mac_i;
            entry_port[free_idx] <= learn_port_i;
        end
    end

    // Learning never creates a duplicate address
    a_unique_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(lookup_hit));

endmodule

//--- hw/sw_macros.svh
//**************************************************************************
// Switch sizing macros: port count, MAC table entries, buffer depths
// and the widths of beats and statistics counters
//**************************************************************************

`ifndef SW_MACROS_SVH
`define SW_MACROS_SVH

`define SW_NUM_PORTS    4
`define SW_MAC_ENTRIES  16

// Ingress buffering per port
`define SW_FIFO_DEPTH   32
`define SW_HDR_DEPTH    4

`define SW_DATA_W       32
`define SW_CNT_W        16

`endif

//--- hw/sw_pkg.sv
//**************************************************************************
// Switch package: vector typedefs and the scheduler state encoding
//**************************************************************************

`include "sw_macros.svh"

package sw_pkg;

    typedef logic [47:0]                        mac_addr_t;
    typedef logic [`SW_DATA_W-1:0]              data_t;
    typedef logic [`SW_NUM_PORTS-1:0]           port_mask_t;  // One bit per port
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0]   port_idx_t;
    typedef logic [`SW_CNT_W-1:0]               count_t;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_DECIDE,
        SCHED_STREAM,
        SCHED_DRAIN     // Empty mask, frame is discarded
    } sched_state_t;

endpackage

//--- hw/sw_top.sv
//**************************************************************************
// Four-port frame switch top: ingress buffers, MAC table, forwarding
// decision and the central frame scheduler
//**************************************************************************

`timescale 1ns/1ps
`include "sw_macros.svh"

module sw_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  sw_pkg::port_mask_t                    rx_valid_i,
    input  sw_pkg::port_mask_t                    rx_sof_i,
    input  sw_pkg::port_mask_t                    rx_eof_i,
    input  sw_pkg::data_t [`SW_NUM_PORTS-1:0]     rx_data_i,
    input  sw_pkg::mac_addr_t [`SW_NUM_PORTS-1:0] rx_dst_i,
    input  sw_pkg::mac_addr_t [`SW_NUM_PORTS-1:0] rx_src_i,
    output sw_pkg::port_mask_t                    rx_ready_o,
    output sw_pkg::port_mask_t                    tx_valid_o,
    output sw_pkg::port_mask_t                    tx_sof_o,
    output sw_pkg::port_mask_t                    tx_eof_o,
    output sw_pkg::data_t [`SW_NUM_PORTS-1:0]     tx_data_o,
    input  sw_pkg::port_mask_t                    tx_ready_i,
    input  logic                                  learning_enable_i,
    input  sw_pkg::port_mask_t                    port_enable_i,
    output sw_pkg::count_t [`SW_NUM_PORTS-1:0]    forwarded_o,
    output sw_pkg::count_t [`SW_NUM_PORTS-1:0]    dropped_o,
    output sw_pkg::count_t                        learned_o
);

    sw_pkg::port_mask_t                    hdr_valid;
    sw_pkg::port_mask_t                    hdr_pop;
    sw_pkg::mac_addr_t [`SW_NUM_PORTS-1:0] hdr_dst;
    sw_pkg::mac_addr_t [`SW_NUM_PORTS-1:0] hdr_src;
    sw_pkg::port_mask_t                    beat_valid;
    sw_pkg::port_mask_t                    beat_eof;
    sw_pkg::port_mask_t                    beat_pop;
    sw_pkg::data_t [`SW_NUM_PORTS-1:0]     beat_data;
    sw_pkg::mac_addr_t                     lookup_mac;
    sw_pkg::mac_addr_t                     learn_mac;
    sw_pkg::port_idx_t                     hit_port;
    sw_pkg::port_idx_t                     learn_port;
    sw_pkg::port_idx_t                     ingress;
    sw_pkg::port_mask_t                    egress_mask;
    logic                                  hit;
    logic                                  learn;

    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_ingress
        ingress_buffer u_ingress_buffer (
            .clk          (clk),
            .rst_n        (rst_n),
            .rx_valid_i   (rx_valid_i[p]),
            .rx_ready_o   (rx_ready_o[p]),
            .rx_sof_i     (rx_sof_i[p]),
            .rx_eof_i     (rx_eof_i[p]),
            .rx_data_i    (rx_data_i[p]),
            .rx_dst_i     (rx_dst_i[p]),
            .rx_src_i     (rx_src_i[p]),
            .hdr_valid_o  (hdr_valid[p]),
            .hdr_dst_o    (hdr_dst[p]),
            .hdr_src_o    (hdr_src[p]),
            .hdr_pop_i    (hdr_pop[p]),
            .beat_valid_o (beat_valid[p]),
            .beat_data_o  (beat_data[p]),
            .beat_eof_o   (beat_eof[p]),
            .beat_pop_i   (beat_pop[p])
        );
    end

    mac_table u_mac_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_mac_i (lookup_mac),
        .hit_o        (hit),
        .hit_port_o   (hit_port),
        .learn_i      (learn),
        .learn_mac_i  (learn_mac),
        .learn_port_i (learn_port),
        .learned_o    (learned_o)
    );

    // Decision sees the header held by the scheduler
    fwd_decide u_fwd_decide (
        .dst_mac_i     (lookup_mac),
        .ingress_i     (ingress),
        .hit_i         (hit),
        .hit_port_i    (hit_port),
        .port_enable_i (port_enable_i),
        .egress_mask_o (egress_mask)
    );

    frame_scheduler u_frame_scheduler (
        .clk               (clk),
        .rst_n             (rst_n),
        .hdr_valid_i       (hdr_valid),
        .hdr_dst_i         (hdr_dst),
        .hdr_src_i         (hdr_src),
        .hdr_pop_o         (hdr_pop),
        .beat_valid_i      (beat_valid),
        .beat_data_i       (beat_data),
        .beat_eof_i        (beat_eof),
        .beat_pop_o        (beat_pop),
        .lookup_mac_o      (lookup_mac),
        .hit_i             (hit),
        .hit_port_i        (hit_port),
        .learn_o           (learn),
        .learn_mac_o       (learn_mac),
        .learn_port_o      (learn_port),
        .ingress_o         (ingress),
        .egress_mask_i     (egress_mask),
        .learning_enable_i (learning_enable_i),
        .tx_valid_o        (tx_valid_o),
        .tx_sof_o          (tx_sof_o),
        .tx_eof_o          (tx_eof_o),
        .tx_data_o         (tx_data_o),
        .tx_ready_i        (tx_ready_i),
        .forwarded_o       (forwarded_o),
        .dropped_o         (dropped_o)
    );

endmodule
